/* core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module core_checker (
    input wire                  clock,
    input wire                  reset_n,
    input wire                  run,
    input wire                  halted,
    input wire core_pkg::addr_t inst_ram_address,
    input wire core_pkg::addr_t data_ram_address,
    input wire core_pkg::word_t data_ram_write_data,
    input wire                  data_ram_write,
    output int                  store_count,
    output int                  pass_count,
    output int                  fail_count,
    output int                  expected_total,
    output logic                halt_checked
);
    import core_pkg::*;

    localparam int max_stores = 64;
    localparam int halt_hold_cycles = 20;

    reg [8*24-1:0] store_name [max_stores];
    addr_t         store_addr [max_stores];
    word_t         store_data [max_stores];

    logic          run_seen;
    logic          idle_done;
    logic          idle_ok;
    logic          halt_seen;
    logic          halt_ok;
    int            halt_cycles;
    addr_t         held_inst_address;
    addr_t         held_data_address;
    integer        fd;
    integer        code;
    logic          file_done;
    reg [8*8-1:0]  key;
    reg [8*200-1:0] rest;
    reg [8*24-1:0] name;
    logic [31:0]   addr_value;
    logic [31:0]   data_value;

    // expected stores come from the store lines only
    initial begin
        store_count    = 0;
        pass_count     = 0;
        fail_count     = 0;
        expected_total = 0;
        run_seen       = 1'b0;
        idle_done      = 1'b0;
        idle_ok        = 1'b1;
        halt_seen      = 1'b0;
        halt_ok        = 1'b1;
        halt_cycles    = 0;
        halt_checked   = 1'b0;
        file_done      = 1'b0;
        fd = $fopen("core_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open core_golden.txt for the expected stores");
            fail_count = 1;
        end else begin
            while (!file_done) begin
                code = $fscanf(fd, "%s", key);
                if (code != 1) begin
                    file_done = 1'b1;
                end else if (key == "store" && expected_total < max_stores) begin
                    code = $fscanf(fd, "%s %h %h", name, addr_value, data_value);
                    store_name[expected_total] = name;
                    store_addr[expected_total] = addr_value[addr_width-1:0];
                    store_data[expected_total] = data_value;
                    expected_total = expected_total + 1;
                end else begin
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    end

    // run is driven on the falling edge, so take it on the rising one
    always @(posedge clock) begin
        if (reset_n === 1'b1 && run === 1'b1) begin
            run_seen <= 1'b1;
        end
    end

    task automatic check_store();
        begin
            if (store_count >= expected_total) begin
                $display("store beyond the expected list: address %h data %h",
                         data_ram_address, data_ram_write_data);
                fail_count = fail_count + 1;
            end else if (data_ram_address !== store_addr[store_count] ||
                         data_ram_write_data !== store_data[store_count]) begin
                $display("ERR %0s expected %h at %h actual %h at %h",
                         store_name[store_count], store_data[store_count],
                         store_addr[store_count], data_ram_write_data, data_ram_address);
                fail_count = fail_count + 1;
            end else begin
                $display("PASS %0s", store_name[store_count]);
                pass_count = pass_count + 1;
            end
            store_count = store_count + 1;
        end
    endtask

    // outputs of the DUT settle well before the falling edge
    always @(negedge clock) begin
        if (!run_seen) begin
            if (halted !== 1'b0 || data_ram_write !== 1'b0) begin
                idle_ok = 1'b0;
            end
        end else begin
            if (!idle_done) begin
                idle_done = 1'b1;
                if (idle_ok) begin
                    $display("PASS idle_reset");
                    pass_count = pass_count + 1;
                end else begin
                    $display("halted or data write was active during reset or while idle");
                    fail_count = fail_count + 1;
                end
            end
            if (data_ram_write === 1'b1) begin
                check_store();
            end
            // once halted the core holds still with every store seen
            if (!halt_seen) begin
                if (halted === 1'b1) begin
                    halt_seen         = 1'b1;
                    held_inst_address = inst_ram_address;
                    held_data_address = data_ram_address;
                end
            end else if (!halt_checked) begin
                if (halted !== 1'b1 || inst_ram_address !== held_inst_address ||
                        data_ram_address !== held_data_address) begin
                    halt_ok = 1'b0;
                end
                halt_cycles = halt_cycles + 1;
                if (halt_cycles == halt_hold_cycles) begin
                    halt_checked = 1'b1;
                    if (halt_ok && store_count == expected_total) begin
                        $display("PASS halt_clean");
                        pass_count = pass_count + 1;
                    end else begin
                        $display("after halt the core saw %0d of %0d stores or did not hold still",
                                 store_count, expected_total);
                        fail_count = fail_count + 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* core_golden.txt */
# prog w0 w1 w2 w3 : four program words placed at the next free word addresses from 0
# data addr word : initial data word ; store name addr word : expected stores in order
prog 06400093 FF900113 002081B3 10302023
prog 40208233 10402223 00309293 10502423
prog 40115313 10602623 01C15393 10702823
prog 00709433 10802A23 001124B3 00113533
prog 10902C23 10A02E23 123455B7 0FF5C613
prog 005666B3 7F06F713 12B02023 12D02223
prog 12E02423 01002783 01402803 00178893
prog 40485913 13102623 13202823 00000A13
prog 00000A93 00208463 001A0A13 00108463
prog 010A0A13 00109463 002A0A13 00209463
prog 020A0A13 0020C463 004A0A13 00114463
prog 040A0A13 13402A23 00115463 001A8A93
prog 0020D463 010A8A93 00116463 002A8A93
prog 0020E463 020A8A93 0020F463 004A8A93
prog 00117463 040A8A93 13502C23 00800B6F
prog 12102E23 13602E23 10000C13 009C0CE7
prog 14102023 14102023 15902023 00100073
prog 14102223 00000000 00000000 00000000
data 0010 00001234
data 0014 80000001
store add 0100 0000005D
store sub 0104 0000006B
store slli 0108 00000320
store srai 010C FFFFFFFC
store srli 0110 0000000F
store sll 0114 00320000
store slt 0118 00000001
store sltu 011C 00000000
store lui 0120 12345000
store xori_or 0124 123453FF
store andi 0128 000003F0
store load_addi 012C 00001235
store load_srai 0130 F8000000
store branch_eq_lt 0134 00000007
store branch_ge_u 0138 00000007
store jal_link 013C 000000F0
store jalr_link 0140 00000100

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int word_width      = 32;
    localparam int addr_width      = 16;
    localparam int reg_index_width = 5;

    typedef logic [word_width-1:0]      word_t;
    typedef logic [addr_width-1:0]      addr_t;
    typedef logic [reg_index_width-1:0] reg_index_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [3:0] {
        state_init,
        state_fetch,
        state_fetch_wait,
        state_decode,
        state_registers,
        state_execute,
        state_load,
        state_load_wait,
        state_store,
        state_retire,
        state_halted
    } core_state_t;

endpackage

`default_nettype wire

/* core_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module core_sequencer (
    input wire                  clock,
    input wire                  reset_n,
    input wire                  run,
    inst_bus_if.consumer        bus,
    input wire core_pkg::word_t result,
    input wire                  branch_taken,
    input wire core_pkg::word_t rs2_value,
    input wire core_pkg::word_t data_read,
    output core_pkg::word_t     pc,
    output logic                latch,
    output core_pkg::addr_t     inst_address,
    output core_pkg::addr_t     data_address,
    output core_pkg::word_t     data_write_data,
    output logic                data_write,
    output logic                rd_write,
    output core_pkg::reg_index_t rd_index,
    output core_pkg::word_t     rd_data,
    output logic                halted
);
    import isa_pkg::*;
    import core_pkg::*;

    core_state_t state;
    logic        branch_reg;
    logic        is_jump;
    logic        writes_rd;
    word_t       pc_plus_len;

    assign is_jump     = (bus.inst_class == inst_jal) || (bus.inst_class == inst_jalr);
    assign writes_rd   = (bus.inst_class == inst_alu_imm) || (bus.inst_class == inst_alu_reg) ||
                         (bus.inst_class == inst_lui) || (bus.inst_class == inst_load) ||
                         is_jump;
    assign pc_plus_len = pc + word_t'(inst_len);

    // decoder captures the fetched word at the end of decode
    assign latch = run && (state == state_decode);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= state_init;
            pc         <= '0;
            data_write <= 1'b0;
            rd_write   <= 1'b0;
            halted     <= 1'b0;
        end else if (run) begin
            case (state)
                state_init: begin
                    pc    <= '0;
                    state <= state_fetch;
                end
                state_fetch: begin
                    // last retire's register write lands on this edge
                    rd_write     <= 1'b0;
                    inst_address <= pc[addr_width-1:0];
                    state        <= state_fetch_wait;
                end
                state_fetch_wait: begin
                    state <= state_decode;
                end
                state_decode: begin
                    state <= state_registers;
                end
                state_registers: begin
                    halted <= (bus.inst_class == inst_system) && (bus.imm[11:0] == ebreak_imm);
                    state  <= state_execute;
                end
                state_execute: begin
                    branch_reg <= branch_taken;
                    if (halted) begin
                        state <= state_halted;
                    end else if (bus.inst_class == inst_load) begin
                        state <= state_load;
                    end else if (bus.inst_class == inst_store) begin
                        state <= state_store;
                    end else begin
                        state <= state_retire;
                    end
                end
                state_load: begin
                    data_address <= result[addr_width-1:0];
                    state        <= state_load_wait;
                end
                state_load_wait: begin
                    state <= state_retire;
                end
                state_store: begin
                    // single-cycle strobe, high during retire
                    data_address    <= result[addr_width-1:0];
                    data_write_data <= rs2_value;
                    data_write      <= 1'b1;
                    state           <= state_retire;
                end
                state_retire: begin
                    data_write <= 1'b0;
                    rd_write   <= writes_rd;
                    rd_index   <= bus.rd;
                    if (is_jump) begin
                        rd_data <= pc_plus_len;
                    end else if (bus.inst_class == inst_load) begin
                        rd_data <= data_read;
                    end else begin
                        rd_data <= result;
                    end
                    // jalr target may be odd, jal never is
                    if (is_jump) begin
                        pc <= {result[word_width-1:1], 1'b0};
                    end else if (branch_reg) begin
                        pc <= result;
                    end else begin
                        pc <= pc_plus_len;
                    end
                    state <= state_fetch;
                end
                state_halted: begin
                    state <= state_halted;
                end
                default: begin
                    state <= state_init;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_tb;
    import core_pkg::*;

    logic  clock = 1'b0;
    logic  reset_n;
    logic  run;
    logic  halted;
    addr_t inst_ram_address;
    word_t inst_ram_read_result;
    addr_t data_ram_address;
    word_t data_ram_write_data;
    logic  data_ram_write;
    word_t data_ram_read_result;

    word_t  inst_mem [256];
    word_t  data_mem [256];
    int     store_count;
    int     pass_count;
    int     fail_count;
    int     expected_total;
    logic   halt_checked;
    int     tb_fail;
    logic   timed_out;

    always #10 clock = ~clock;

    shader_core DUT (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .halted               (halted),
        .inst_ram_address     (inst_ram_address),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_address     (data_ram_address),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write),
        .data_ram_read_result (data_ram_read_result)
    );

    core_checker scoreboard (
        .clock               (clock),
        .reset_n             (reset_n),
        .run                 (run),
        .halted              (halted),
        .inst_ram_address    (inst_ram_address),
        .data_ram_address    (data_ram_address),
        .data_ram_write_data (data_ram_write_data),
        .data_ram_write      (data_ram_write),
        .store_count         (store_count),
        .pass_count          (pass_count),
        .fail_count          (fail_count),
        .expected_total      (expected_total),
        .halt_checked        (halt_checked)
    );

    // both memories answer one clock after the address, byte addressed
    always @(posedge clock) begin
        inst_ram_read_result <= inst_mem[inst_ram_address[9:2]];
        if (data_ram_write === 1'b1) begin
            data_mem[data_ram_address[9:2]] <= data_ram_write_data;
        end
        data_ram_read_result <= data_mem[data_ram_address[9:2]];
    end

    task automatic load_golden();
        integer       fd;
        integer       code;
        integer       next_word;
        logic         file_done;
        reg [8*8-1:0] key;
        reg [8*200-1:0] rest;
        logic [31:0]  w0;
        logic [31:0]  w1;
        logic [31:0]  w2;
        logic [31:0]  w3;
        begin
            next_word = 0;
            file_done = 1'b0;
            for (int i = 0; i < 256; i++) begin
                inst_mem[i] = '0;
                data_mem[i] = '0;
            end
            fd = $fopen("core_golden.txt", "r");
            if (fd == 0) begin
                $display("could not open core_golden.txt for program and data");
                tb_fail = tb_fail + 1;
            end else begin
                while (!file_done) begin
                    code = $fscanf(fd, "%s", key);
                    if (code != 1) begin
                        file_done = 1'b1;
                    end else if (key == "prog") begin
                        code = $fscanf(fd, "%h %h %h %h", w0, w1, w2, w3);
                        inst_mem[next_word]     = w0;
                        inst_mem[next_word + 1] = w1;
                        inst_mem[next_word + 2] = w2;
                        inst_mem[next_word + 3] = w3;
                        next_word = next_word + 4;
                    end else if (key == "data") begin
                        code = $fscanf(fd, "%h %h", w0, w1);
                        data_mem[w0[9:2]] = w1;
                    end else begin
                        code = $fgets(rest, fd);
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    task automatic wait_for_store(input int index, input int limit);
        int cycles;
        begin
            cycles = 0;
            while (!timed_out && store_count <= index && cycles < limit) begin
                @(posedge clock);
                cycles = cycles + 1;
            end
            if (!timed_out && store_count <= index) begin
                $display("timeout: store number %0d did not appear within %0d cycles",
                         index, limit);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_for_halt(input int limit);
        int cycles;
        begin
            cycles = 0;
            while (!timed_out && halted !== 1'b1 && cycles < limit) begin
                @(posedge clock);
                cycles = cycles + 1;
            end
            if (!timed_out && halted !== 1'b1) begin
                $display("timeout: the core did not halt within %0d cycles", limit);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_for_halt_check(input int limit);
        int cycles;
        begin
            cycles = 0;
            while (!timed_out && halt_checked !== 1'b1 && cycles < limit) begin
                @(posedge clock);
                cycles = cycles + 1;
            end
            if (!timed_out && halt_checked !== 1'b1) begin
                $display("timeout: the checks after halt did not finish within %0d cycles",
                         limit);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        reset_n              = 1'b0;
        run                  = 1'b0;
        inst_ram_read_result = '0;
        data_ram_read_result = '0;
        timed_out            = 1'b0;
        tb_fail              = 0;
        load_golden();
        repeat (5) @(negedge clock);
        reset_n = 1'b1;
        // run low long enough that a free-running core would reach its first store
        repeat (30) @(negedge clock);
        run = 1'b1;
        for (int k = 0; k < expected_total; k++) begin
            wait_for_store(k, 400);
        end
        wait_for_halt(400);
        wait_for_halt_check(40);
        $display("tests passed %0d, failed %0d", pass_count, fail_count + tb_fail);
        if (!timed_out && fail_count == 0 && tb_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* execute_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    inst_bus_if.consumer        bus,
    input wire core_pkg::word_t pc,
    input wire core_pkg::word_t rs1_value,
    input wire core_pkg::word_t rs2_value,
    output core_pkg::word_t     result,
    output logic                branch_taken
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t   operand1;
    word_t   operand2;
    alu_op_t operation;
    logic    is_alu;
    logic    is_shift;
    logic    compare;

    assign is_alu   = (bus.inst_class == inst_alu_imm) || (bus.inst_class == inst_alu_reg);
    assign is_shift = (bus.funct3 == funct3_sll) || (bus.funct3 == funct3_shr);

    // branch and jal targets are pc relative
    always_comb begin
        case (bus.inst_class)
            inst_branch, inst_jal: operand1 = pc;
            inst_lui:              operand1 = bus.imm;
            default:               operand1 = rs1_value;
        endcase
    end

    // shifts only see a 5-bit amount, srai has bit 30 set in its immediate
    always_comb begin
        case (bus.inst_class)
            inst_alu_imm: operand2 = is_shift ? word_t'(bus.imm[4:0]) : bus.imm;
            inst_alu_reg: operand2 = is_shift ? word_t'(rs2_value[4:0]) : rs2_value;
            inst_lui:     operand2 = '0;
            default:      operand2 = bus.imm;
        endcase
    end

    always_comb begin
        operation = alu_add;
        if (is_alu) begin
            case (bus.funct3)
                funct3_add: begin
                    // no subi, so alt only counts for register ops
                    if (bus.alt && (bus.inst_class == inst_alu_reg)) begin
                        operation = alu_sub;
                    end else begin
                        operation = alu_add;
                    end
                end
                funct3_sll:  operation = alu_sll;
                funct3_slt:  operation = alu_slt;
                funct3_sltu: operation = alu_sltu;
                funct3_xor:  operation = alu_xor;
                funct3_shr:  operation = bus.alt ? alu_sra : alu_srl;
                funct3_or:   operation = alu_or;
                funct3_and:  operation = alu_and;
                default:     operation = alu_add;
            endcase
        end
    end

    always_comb begin
        case (operation)
            alu_add:  result = operand1 + operand2;
            alu_sub:  result = operand1 - operand2;
            alu_sll:  result = operand1 << operand2;
            alu_slt:  result = word_t'($signed(operand1) < $signed(operand2));
            alu_sltu: result = word_t'(operand1 < operand2);
            alu_xor:  result = operand1 ^ operand2;
            alu_srl:  result = operand1 >> operand2;
            alu_sra:  result = word_t'($signed(operand1) >>> operand2);
            alu_or:   result = operand1 | operand2;
            alu_and:  result = operand1 & operand2;
            default:  result = '0;
        endcase
    end

    // comparison is on the registers, the alu forms the target
    always_comb begin
        case (bus.funct3)
            funct3_beq:  compare = (rs1_value == rs2_value);
            funct3_bne:  compare = (rs1_value != rs2_value);
            funct3_blt:  compare = ($signed(rs1_value) < $signed(rs2_value));
            funct3_bge:  compare = ($signed(rs1_value) >= $signed(rs2_value));
            funct3_bltu: compare = (rs1_value < rs2_value);
            funct3_bgeu: compare = (rs1_value >= rs2_value);
            default:     compare = 1'b0;
        endcase
    end

    assign branch_taken = (bus.inst_class == inst_branch) && compare;

endmodule

`default_nettype wire

/* filelist.f */
core_pkg.sv
isa_pkg.sv
inst_bus_if.sv
inst_decoder.sv
register_file.sv
execute_unit.sv
core_sequencer.sv
shader_core.sv
core_checker.sv
core_tb.sv

/* inst_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface inst_bus_if;
    import isa_pkg::*;
    import core_pkg::*;

    inst_class_t inst_class;
    reg_index_t  rd;
    reg_index_t  rs1;
    reg_index_t  rs2;
    logic [2:0]  funct3;
    // instruction bit 30
    logic        alt;
    // sign-extended for the format of the class
    word_t       imm;

    modport decoder (
        output inst_class, rd, rs1, rs2, funct3, alt, imm
    );

    modport consumer (
        input inst_class, rd, rs1, rs2, funct3, alt, imm
    );

endinterface

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input wire                 clock,
    input wire                 reset_n,
    input wire                 latch,
    input wire core_pkg::word_t inst_word,
    inst_bus_if.decoder        bus
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t       inst_reg;
    inst_class_t inst_class;
    word_t       imm;

    // an all-zero word decodes as illegal
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            inst_reg <= '0;
        end else if (latch) begin
            inst_reg <= inst_word;
        end
    end

    always_comb begin
        case (inst_reg[6:0])
            opcode_op_imm: inst_class = inst_alu_imm;
            opcode_op_reg: inst_class = inst_alu_reg;
            opcode_branch: inst_class = inst_branch;
            opcode_jal:    inst_class = inst_jal;
            opcode_jalr:   inst_class = inst_jalr;
            opcode_lui:    inst_class = inst_lui;
            opcode_load:   inst_class = inst_load;
            opcode_store:  inst_class = inst_store;
            opcode_system: inst_class = inst_system;
            default:       inst_class = inst_illegal;
        endcase
    end

    // immediate by format
    always_comb begin
        case (inst_class)
            inst_alu_imm, inst_jalr, inst_load, inst_system: begin
                imm = {{20{inst_reg[31]}}, inst_reg[31:20]};
            end
            inst_store: begin
                imm = {{20{inst_reg[31]}}, inst_reg[31:25], inst_reg[11:7]};
            end
            inst_branch: begin
                imm = {{19{inst_reg[31]}}, inst_reg[31], inst_reg[7],
                       inst_reg[30:25], inst_reg[11:8], 1'b0};
            end
            inst_lui: begin
                imm = {inst_reg[31:12], 12'b0};
            end
            inst_jal: begin
                imm = {{11{inst_reg[31]}}, inst_reg[31], inst_reg[19:12],
                       inst_reg[20], inst_reg[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    assign bus.inst_class = inst_class;
    assign bus.rd         = inst_reg[11:7];
    assign bus.rs1        = inst_reg[19:15];
    assign bus.rs2        = inst_reg[24:20];
    assign bus.funct3     = inst_reg[14:12];
    assign bus.alt        = inst_reg[30];
    assign bus.imm        = imm;

endmodule

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // major opcodes, instruction bits 6:0
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op_reg = 7'b0110011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_system = 7'b1110011;

    // alu variants, bit 30 picks sub and sra
    localparam logic [2:0] funct3_add  = 3'd0;
    localparam logic [2:0] funct3_sll  = 3'd1;
    localparam logic [2:0] funct3_slt  = 3'd2;
    localparam logic [2:0] funct3_sltu = 3'd3;
    localparam logic [2:0] funct3_xor  = 3'd4;
    localparam logic [2:0] funct3_shr  = 3'd5;
    localparam logic [2:0] funct3_or   = 3'd6;
    localparam logic [2:0] funct3_and  = 3'd7;

    // branch variants
    localparam logic [2:0] funct3_beq  = 3'd0;
    localparam logic [2:0] funct3_bne  = 3'd1;
    localparam logic [2:0] funct3_blt  = 3'd4;
    localparam logic [2:0] funct3_bge  = 3'd5;
    localparam logic [2:0] funct3_bltu = 3'd6;
    localparam logic [2:0] funct3_bgeu = 3'd7;

    // system opcode with this I immediate halts the core
    localparam logic [11:0] ebreak_imm = 12'd1;

    localparam int unsigned inst_len = 4;

    typedef enum logic [3:0] {
        inst_alu_imm,
        inst_alu_reg,
        inst_branch,
        inst_jal,
        inst_jalr,
        inst_lui,
        inst_load,
        inst_store,
        inst_system,
        inst_illegal
    } inst_class_t;

endpackage

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file #(
    parameter int width = core_pkg::word_width,
    parameter int depth = 2 ** core_pkg::reg_index_width
) (
    input wire                     clock,
    input wire                     write,
    input wire [$clog2(depth)-1:0] write_index,
    input wire [width-1:0]         write_data,
    input wire [$clog2(depth)-1:0] read1_index,
    output logic [width-1:0]       read1_data,
    input wire [$clog2(depth)-1:0] read2_index,
    output logic [width-1:0]       read2_data
);

    logic [width-1:0] bank [depth];

    // entry 0 is never written
    always_ff @(posedge clock) begin
        if (write && (write_index != '0)) begin
            bank[write_index] <= write_data;
        end
    end

    // x0 reads as zero even though the entry is never initialised
    assign read1_data = (read1_index == '0) ? '0 : bank[read1_index];
    assign read2_data = (read2_index == '0) ? '0 : bank[read2_index];

endmodule

`default_nettype wire

/* shader_core.sv */
`timescale 1ns/1ns
`default_nettype none

module shader_core (
    input wire                  clock,
    input wire                  reset_n,
    input wire                  run,
    output logic                halted,
    output core_pkg::addr_t     inst_ram_address,
    input wire core_pkg::word_t inst_ram_read_result,
    output core_pkg::addr_t     data_ram_address,
    output core_pkg::word_t     data_ram_write_data,
    output logic                data_ram_write,
    input wire core_pkg::word_t data_ram_read_result
);
    import core_pkg::*;

    word_t      pc;
    word_t      rs1_value;
    word_t      rs2_value;
    word_t      result;
    logic       branch_taken;
    logic       latch;
    logic       rd_write;
    reg_index_t rd_index;
    word_t      rd_data;

    inst_bus_if bus ();

    inst_decoder decoder (
        .clock     (clock),
        .reset_n   (reset_n),
        .latch     (latch),
        .inst_word (inst_ram_read_result),
        .bus       (bus.decoder)
    );

    // source indices come straight off the decoded instruction
    register_file #(
        .width (word_width),
        .depth (2 ** reg_index_width)
    ) registers (
        .clock       (clock),
        .write       (rd_write),
        .write_index (rd_index),
        .write_data  (rd_data),
        .read1_index (bus.rs1),
        .read1_data  (rs1_value),
        .read2_index (bus.rs2),
        .read2_data  (rs2_value)
    );

    execute_unit execute (
        .bus          (bus.consumer),
        .pc           (pc),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .result       (result),
        .branch_taken (branch_taken)
    );

    core_sequencer sequencer (
        .clock           (clock),
        .reset_n         (reset_n),
        .run             (run),
        .bus             (bus.consumer),
        .result          (result),
        .branch_taken    (branch_taken),
        .rs2_value       (rs2_value),
        .data_read       (data_ram_read_result),
        .pc              (pc),
        .latch           (latch),
        .inst_address    (inst_ram_address),
        .data_address    (data_ram_address),
        .data_write_data (data_ram_write_data),
        .data_write      (data_ram_write),
        .rd_write        (rd_write),
        .rd_index        (rd_index),
        .rd_data         (rd_data),
        .halted          (halted)
    );

endmodule

`default_nettype wire
